/* list.f */
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/id_ex_reg.sv
rtl/exec_mem_stage.sv
rtl/hazard_unit.sv
rtl/wb_arbiter.sv
rtl/cpu_core_top.sv
dv/wb_mem_model.sv
dv/tb_cpu_core.sv

/* dv/tb_cpu_core.sv */
`timescale 1ns/100ps

module tb_cpu_core;

    localparam isa_pkg::word_t RESET_PC = 32'h0;
    localparam int TOTAL_INSTR = 38;            // all test programs together
    localparam int CLK_NS = 4;

    logic              clk = 1'b0;
    logic              rst_n = 1'b0;
    logic              halted;
    pipe_pkg::wb_req_t bus_req;
    pipe_pkg::wb_rsp_t bus_rsp;
    isa_pkg::word_t    ref_mem [256];           // reference image
    isa_pkg::word_t    prog [$];
    pipe_pkg::wb_req_t last_req;
    logic              pend = 1'b0;             // access open at the last edge

    always #2 clk = ~clk;

    cpu_core_top #(.RESET_PC(RESET_PC)) DUT (
        .clk(clk), .rst_n(rst_n), .bus_rsp(bus_rsp), .bus_req(bus_req), .halted(halted)
    );

    wb_mem_model #(.SEED(32'h28da_5260)) u_mem (
        .clk(clk), .rst_n(rst_n), .req(bus_req), .rsp(bus_rsp)
    );

    task automatic check_word(isa_pkg::word_t got, isa_pkg::word_t exp, string msg);
        if (got !== exp) begin
            $display("FAIL @%0t: %s got %h expected %h", $time, msg, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_bus_req(pipe_pkg::wb_req_t got, pipe_pkg::wb_req_t exp, string msg);
        if (got !== exp) begin
            $display("FAIL @%0t: %s got %h expected %h", $time, msg, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "bus request mismatch");
        end
    endtask

    task automatic check_flag(logic got, logic exp, string msg);
        if (got !== exp) begin
            $display("FAIL @%0t: %s got %b expected %b", $time, msg, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "flag mismatch");
        end
    endtask

    function automatic isa_pkg::word_t enc(isa_pkg::opcode_e op, isa_pkg::reg_idx_t rd,
            isa_pkg::reg_idx_t rs1, isa_pkg::reg_idx_t rs2, logic [15:0] imm);
        isa_pkg::instr_t i;
        i = '{opcode: op, rd: rd, rs1: rs1, rs2: rs2, imm: imm};
        return isa_pkg::word_t'(i);
    endfunction

    // wishbone request must not move while the slave has not answered
    always @(posedge clk) begin
        if (rst_n && pend)
            check_bus_req(bus_req, last_req, "request changed before ack");
        pend     <= rst_n && bus_req.cyc && !bus_rsp.ack;
        last_req <= bus_req;
    end

    initial begin
        #(TOTAL_INSTR * 300 * CLK_NS);
        $display("watchdog: the core never halted within the time limit");
        $display("ERRORS FOUND");
        $fatal(1, "timeout");
    end

    task automatic simulate_reference();
        isa_pkg::word_t  r [16];
        isa_pkg::word_t  pc;
        isa_pkg::word_t  imm;
        isa_pkg::instr_t ins;
        int              steps;
        for (int i = 0; i < 16; i++)
            r[i] = '0;
        pc = RESET_PC;
        for (steps = 0; steps < 1000; steps++) begin
            ins = isa_pkg::instr_t'(ref_mem[pc[9:2]]);
            imm = {{16{ins.imm[15]}}, ins.imm};
            pc  = pc + 32'd4;
            case (ins.opcode)
                isa_pkg::OP_ADD:  r[ins.rd] = r[ins.rs1] + r[ins.rs2];
                isa_pkg::OP_SUB:  r[ins.rd] = r[ins.rs1] - r[ins.rs2];
                isa_pkg::OP_AND:  r[ins.rd] = r[ins.rs1] & r[ins.rs2];
                isa_pkg::OP_OR:   r[ins.rd] = r[ins.rs1] | r[ins.rs2];
                isa_pkg::OP_XOR:  r[ins.rd] = r[ins.rs1] ^ r[ins.rs2];
                isa_pkg::OP_ADDI: r[ins.rd] = r[ins.rs1] + imm;
                isa_pkg::OP_LW:   r[ins.rd] = ref_mem[(r[ins.rs1] + imm) >> 2 & 255];
                isa_pkg::OP_SW:   ref_mem[(r[ins.rs1] + imm) >> 2 & 255] = r[ins.rs2];
                isa_pkg::OP_HALT: break;
                default: ;                      // NOP
            endcase
            r[0] = '0;
        end
    endtask

    // load memory, reset, run to HALT, compare the data region
    task automatic run_program(string name);
        isa_pkg::word_t addr;
        pipe_pkg::wb_req_t first;
        for (int i = 0; i < 256; i++) begin
            addr = i * 4;
            u_mem.mem[i] = (addr * 32'h0101_0101) ^ (addr << 13) ^ 32'h5a5a_0000;
        end
        foreach (prog[i])
            u_mem.mem[i] = prog[i];
        for (int i = 0; i < 256; i++)
            ref_mem[i] = u_mem.mem[i];
        simulate_reference();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (16) begin
            @(posedge clk);
            check_flag(bus_req.cyc, 1'b0, "cyc in reset");
            check_flag(bus_req.stb, 1'b0, "stb in reset");
            check_flag(halted, 1'b0, "halted in reset");
        end
        rst_n <= 1'b1;
        @(posedge clk);
        while (!bus_req.cyc) begin
            check_flag(halted, 1'b0, "halted before first fetch");
            @(posedge clk);
        end
        first = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: RESET_PC, dat_w: '0, sel: 4'hf};
        check_bus_req(bus_req, first, "first access");
        while (!halted)
            @(posedge clk);
        repeat (20) begin
            @(posedge clk);
            check_flag(bus_req.cyc, 1'b0, "bus cycle after halt");
            check_flag(halted, 1'b1, "halted dropped");
        end
        for (int i = 128; i < 192; i++)
            check_word(u_mem.mem[i], ref_mem[i], $sformatf("%s mem[%h]", name, i * 4));
    endtask

    task automatic alu_ops();
        prog = {};
        prog.push_back(enc(isa_pkg::OP_ADDI, 1, 0, 0, 16'h0123));
        prog.push_back(enc(isa_pkg::OP_ADDI, 2, 0, 0, 16'hfffb));   // -5
        prog.push_back(enc(isa_pkg::OP_ADD, 3, 1, 2, 0));
        prog.push_back(enc(isa_pkg::OP_SUB, 4, 1, 2, 0));
        prog.push_back(enc(isa_pkg::OP_AND, 5, 1, 2, 0));
        prog.push_back(enc(isa_pkg::OP_OR, 6, 1, 2, 0));
        prog.push_back(enc(isa_pkg::OP_XOR, 7, 1, 2, 0));
        for (int k = 1; k < 8; k++)
            prog.push_back(enc(isa_pkg::OP_SW, 0, 0, k, 16'h0200 + 16'(k * 4)));
        prog.push_back(enc(isa_pkg::OP_HALT, 0, 0, 0, 0));
        run_program("alu");
    endtask

    task automatic dependency_chain();
        prog = {};
        prog.push_back(enc(isa_pkg::OP_ADDI, 1, 0, 0, 16'd7));
        prog.push_back(enc(isa_pkg::OP_ADD, 2, 1, 1, 0));
        prog.push_back(enc(isa_pkg::OP_SUB, 3, 2, 1, 0));
        prog.push_back(enc(isa_pkg::OP_XOR, 4, 3, 2, 0));
        prog.push_back(enc(isa_pkg::OP_OR, 5, 4, 3, 0));
        prog.push_back(enc(isa_pkg::OP_ADDI, 5, 5, 0, 16'hffff));
        prog.push_back(enc(isa_pkg::OP_SW, 0, 0, 5, 16'h0220));
        prog.push_back(enc(isa_pkg::OP_HALT, 0, 0, 0, 0));
        run_program("dependencies");
    endtask

    task automatic load_use();
        prog = {};
        prog.push_back(enc(isa_pkg::OP_LW, 1, 0, 0, 16'h0200));
        prog.push_back(enc(isa_pkg::OP_ADD, 2, 1, 1, 0));          // uses the load at once
        prog.push_back(enc(isa_pkg::OP_SW, 0, 0, 2, 16'h0240));
        prog.push_back(enc(isa_pkg::OP_HALT, 0, 0, 0, 0));
        run_program("load-use");
    endtask

    task automatic bus_contention();
        prog = {};
        prog.push_back(enc(isa_pkg::OP_ADDI, 8, 0, 0, 16'h0200));
        prog.push_back(enc(isa_pkg::OP_LW, 1, 8, 0, 16'h0000));
        prog.push_back(enc(isa_pkg::OP_SW, 0, 8, 1, 16'h0040));
        prog.push_back(enc(isa_pkg::OP_LW, 2, 8, 0, 16'h0004));
        prog.push_back(enc(isa_pkg::OP_ADD, 3, 1, 2, 0));
        prog.push_back(enc(isa_pkg::OP_SW, 0, 8, 3, 16'h0044));
        prog.push_back(enc(isa_pkg::OP_LW, 4, 8, 0, 16'h0044));   // reads back the store
        prog.push_back(enc(isa_pkg::OP_XOR, 5, 4, 2, 0));
        prog.push_back(enc(isa_pkg::OP_SW, 0, 8, 5, 16'h0048));
        prog.push_back(enc(isa_pkg::OP_SW, 0, 8, 2, 16'h004c));
        prog.push_back(enc(isa_pkg::OP_HALT, 0, 0, 0, 0));
        run_program("contention");
    endtask

    initial begin
        alu_ops();
        dependency_chain();
        load_use();
        bus_contention();
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* dv/wb_mem_model.sv */
`timescale 1ns/100ps

module wb_mem_model #(
    parameter logic [31:0] SEED = 32'h28da_5260
) (
    input  logic              clk,
    input  logic              rst_n,
    input  pipe_pkg::wb_req_t req,
    output pipe_pkg::wb_rsp_t rsp
);

    isa_pkg::word_t mem [256];                  // 1 KiB, word addressed by adr[9:2]
    logic [31:0]    lcg;
    logic [1:0]     wait_cnt;                   // wait states left for this access

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp      <= '0;
            lcg      <= SEED;
            wait_cnt <= 2'd0;
        end else if (rsp.ack) begin
            rsp.ack <= 1'b0;                    // one cycle ack, then idle a cycle
        end else if (req.cyc && req.stb) begin
            if (wait_cnt == 2'd0) begin
                rsp.ack <= 1'b1;
                if (req.we)
                    mem[req.adr[9:2]] <= req.dat_w;
                else
                    rsp.dat_r <= mem[req.adr[9:2]];
                lcg      <= lcg_next(lcg);
                wait_cnt <= lcg[17:16];         // 0..3 for the next access
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule

/* rtl/cpu_core_top.sv */
`timescale 1ns/100ps

module cpu_core_top #(
    parameter isa_pkg::word_t RESET_PC = '0     // first fetch address
) (
    input  logic              clk,
    input  logic              rst_n,
    input  pipe_pkg::wb_rsp_t bus_rsp,
    output pipe_pkg::wb_req_t bus_req,          // shared wishbone port
    output logic              halted
);

    pipe_pkg::if_id_t       if_id;
    pipe_pkg::id_ex_t       id_payload;
    pipe_pkg::id_ex_t       ex_payload;
    pipe_pkg::ex_mem_t      mem_dest;
    pipe_pkg::hazard_ctrl_t hazard_control;
    pipe_pkg::wb_req_t      fetch_req;
    pipe_pkg::wb_req_t      data_req;
    pipe_pkg::wb_rsp_t      fetch_rsp;
    pipe_pkg::wb_rsp_t      data_rsp;
    logic                   id_no_op;
    logic                   ex_no_op;
    logic                   fetch_hold;
    logic                   mem_busy;
    logic [1:0]             src_used;
    isa_pkg::reg_idx_t      rs1_idx;
    isa_pkg::reg_idx_t      rs2_idx;
    logic                   wr_en;              // writeback into decode
    isa_pkg::reg_idx_t      wr_idx;
    isa_pkg::word_t         wr_data;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .rst_n(rst_n), .fetch_hold(fetch_hold), .bus_rsp(fetch_rsp),
        .bus_req(fetch_req), .if_id(if_id), .halted(halted)
    );

    decode_stage u_decode (
        .clk(clk), .rst_n(rst_n), .if_id(if_id),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
        .id_payload(id_payload), .id_no_op(id_no_op),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .src_used(src_used)
    );

    id_ex_reg u_id_ex (
        .clk(clk), .rst_n(rst_n), .hazard_control(hazard_control),
        .id_no_op(id_no_op), .id_payload(id_payload),
        .ex_payload(ex_payload), .ex_no_op(ex_no_op)
    );

    exec_mem_stage u_exec_mem (
        .clk(clk), .rst_n(rst_n), .ex_payload(ex_payload), .ex_no_op(ex_no_op),
        .bus_rsp(data_rsp), .bus_req(data_req),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
        .mem_busy(mem_busy), .mem_dest(mem_dest)
    );

    hazard_unit u_hazard (
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .src_used(src_used),
        .ex_payload(ex_payload), .ex_no_op(ex_no_op),
        .mem_dest(mem_dest), .mem_busy(mem_busy),
        .hazard_control(hazard_control), .fetch_hold(fetch_hold)
    );

    wb_arbiter u_arbiter (
        .clk(clk), .rst_n(rst_n),
        .fetch_req(fetch_req), .data_req(data_req), .bus_rsp(bus_rsp),
        .fetch_rsp(fetch_rsp), .data_rsp(data_rsp), .bus_req(bus_req)
    );

endmodule

/* rtl/wb_arbiter.sv */
`timescale 1ns/100ps

module wb_arbiter (
    input  logic              clk,
    input  logic              rst_n,
    input  pipe_pkg::wb_req_t fetch_req,
    input  pipe_pkg::wb_req_t data_req,
    input  pipe_pkg::wb_rsp_t bus_rsp,          // external slave
    output pipe_pkg::wb_rsp_t fetch_rsp,
    output pipe_pkg::wb_rsp_t data_rsp,
    output pipe_pkg::wb_req_t bus_req
);

    logic data_owns;                            // last grant, 1 data, 0 fetch
    logic keep;                                 // owner still inside its cycle
    logic sel_data;

    assign keep     = data_owns ? data_req.cyc : fetch_req.cyc;
    assign sel_data = keep ? data_owns : data_req.cyc;     // free bus, data first

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            data_owns <= 1'b0;
        else
            data_owns <= sel_data;
    end

    assign bus_req = sel_data ? data_req : fetch_req;

    always_comb begin
        fetch_rsp = '0;
        data_rsp  = '0;
        if (sel_data)
            data_rsp = bus_rsp;
        else
            fetch_rsp = bus_rsp;               // loser never sees ack
    end

    grant_held: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req.cyc && !bus_rsp.ack |=> sel_data == $past(sel_data));

    ack_to_active: assert property (@(posedge clk) disable iff (!rst_n)
        bus_rsp.ack |-> (sel_data ? data_req.cyc : fetch_req.cyc));

endmodule

/* rtl/hazard_unit.sv */
`timescale 1ns/100ps

module hazard_unit (
    input  isa_pkg::reg_idx_t      rs1_idx,
    input  isa_pkg::reg_idx_t      rs2_idx,
    input  logic [1:0]             src_used,
    input  pipe_pkg::id_ex_t       ex_payload,
    input  logic                   ex_no_op,
    input  pipe_pkg::ex_mem_t      mem_dest,
    input  logic                   mem_busy,
    output pipe_pkg::hazard_ctrl_t hazard_control,
    output logic                   fetch_hold      // decode instruction must wait
);

    logic hit_ex;                               // source produced in execute
    logic hit_mem;                              // source is a load still in flight

    function automatic logic src_hit(isa_pkg::reg_idx_t dest);
        return (dest != '0) && ((src_used[0] && rs1_idx == dest) ||
                                (src_used[1] && rs2_idx == dest));
    endfunction

    always_comb begin
        hit_ex  = !ex_no_op && ex_payload.reg_write && src_hit(ex_payload.reg_dest_idx);
        // ALU results in memory reach decode through register write-through
        hit_mem = mem_dest.valid && mem_dest.reg_write && mem_dest.mem_read &&
                  src_hit(mem_dest.reg_dest_idx);
    end

    assign hazard_control.hold  = mem_busy;
    assign hazard_control.no_op = hit_ex | hit_mem;
    assign fetch_hold           = mem_busy | hit_ex | hit_mem;

endmodule

/* rtl/exec_mem_stage.sv */
`timescale 1ns/100ps

module exec_mem_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  pipe_pkg::id_ex_t  ex_payload,
    input  logic              ex_no_op,
    input  pipe_pkg::wb_rsp_t bus_rsp,
    output pipe_pkg::wb_req_t bus_req,          // data master
    output logic              wr_en,            // register writeback
    output isa_pkg::reg_idx_t wr_idx,
    output isa_pkg::word_t    wr_data,
    output logic              mem_busy,         // memory op not yet acked
    output pipe_pkg::ex_mem_t mem_dest          // execute/memory register
);

    pipe_pkg::bus_state_e state;
    isa_pkg::word_t       alu_result;
    logic                 ex_mem_op;            // live LW or SW in execute

    always_comb begin
        case (ex_payload.alu_op)
            isa_pkg::ALU_ADD: alu_result = ex_payload.operand_1 + ex_payload.operand_2;
            isa_pkg::ALU_SUB: alu_result = ex_payload.operand_1 - ex_payload.operand_2;
            isa_pkg::ALU_AND: alu_result = ex_payload.operand_1 & ex_payload.operand_2;
            isa_pkg::ALU_OR:  alu_result = ex_payload.operand_1 | ex_payload.operand_2;
            isa_pkg::ALU_XOR: alu_result = ex_payload.operand_1 ^ ex_payload.operand_2;
            default:          alu_result = ex_payload.operand_2;   // pass
        endcase
    end

    assign ex_mem_op = !ex_no_op && (ex_payload.mem_read || ex_payload.mem_write);
    // busy from entry up to, not including, the ack cycle
    assign mem_busy  = (state == pipe_pkg::IDLE) ? ex_mem_op : !bus_rsp.ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= pipe_pkg::IDLE;
            bus_req  <= '0;
            mem_dest <= '0;
        end else begin
            case (state)
                pipe_pkg::IDLE: begin
                    mem_dest <= '{
                        reg_write:    ex_payload.reg_write && !ex_no_op,
                        mem_write:    ex_payload.mem_write && !ex_no_op,
                        mem_read:     ex_payload.mem_read && !ex_no_op,
                        result:       alu_result,
                        store_data:   ex_payload.store_data,
                        reg_dest_idx: ex_payload.reg_dest_idx,
                        valid:        !ex_no_op
                    };
                    if (ex_mem_op) begin
                        bus_req.cyc   <= 1'b1;
                        bus_req.stb   <= 1'b1;
                        bus_req.we    <= ex_payload.mem_write;
                        bus_req.adr   <= alu_result;
                        bus_req.dat_w <= ex_payload.store_data;
                        bus_req.sel   <= 4'hf;  // whole words only
                        state         <= pipe_pkg::WAIT_ACK;
                    end
                end
                pipe_pkg::WAIT_ACK: begin
                    if (bus_rsp.ack) begin
                        bus_req.cyc    <= 1'b0;
                        bus_req.stb    <= 1'b0;
                        mem_dest.valid <= 1'b0; // retired
                        state          <= pipe_pkg::IDLE;
                    end
                end
                default: state <= pipe_pkg::IDLE;
            endcase
        end
    end

    // ALU results write the cycle after execute, loads on their ack
    assign wr_en   = mem_dest.valid && mem_dest.reg_write && (!mem_dest.mem_read || bus_rsp.ack);
    assign wr_idx  = mem_dest.reg_dest_idx;
    assign wr_data = mem_dest.mem_read ? bus_rsp.dat_r : mem_dest.result;

endmodule

/* rtl/id_ex_reg.sv */
`timescale 1ns/100ps

module id_ex_reg (
    input  logic                   clk,
    input  logic                   rst_n,
    input  pipe_pkg::hazard_ctrl_t hazard_control,  // from hazard_unit
    input  logic                   id_no_op,        // decode had nothing valid
    input  pipe_pkg::id_ex_t       id_payload,
    output pipe_pkg::id_ex_t       ex_payload,      // to exec_mem_stage
    output logic                   ex_no_op         // execute ignores its payload
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_payload <= '0;
            ex_no_op   <= 1'b0;
        end else begin
            if (!hazard_control.hold)
                ex_payload <= id_payload;   // held while a data access is open
            if (hazard_control == pipe_pkg::HAZD_RESUME)
                ex_no_op <= 1'b0;
            else
                ex_no_op <= hazard_control.no_op | id_no_op;
        end
    end

    // only an open data access may freeze execute
    hold_on_mem_access: assert property (@(posedge clk) disable iff (!rst_n)
        hazard_control.hold |-> ex_payload.mem_read || ex_payload.mem_write);

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  pipe_pkg::if_id_t  if_id,
    input  logic              wr_en,            // writeback port
    input  isa_pkg::reg_idx_t wr_idx,
    input  isa_pkg::word_t    wr_data,
    output pipe_pkg::id_ex_t  id_payload,
    output logic              id_no_op,         // nothing to execute this cycle
    output isa_pkg::reg_idx_t rs1_idx,
    output isa_pkg::reg_idx_t rs2_idx,
    output logic [1:0]        src_used          // [0] rs1 read, [1] rs2 read
);

    isa_pkg::word_t regs [16];
    isa_pkg::word_t rs1_val;
    isa_pkg::word_t rs2_val;
    isa_pkg::word_t imm_ext;
    logic           use_imm;                    // operand 2 from immediate

    function automatic isa_pkg::word_t read_reg(isa_pkg::reg_idx_t idx);
        if (idx == '0)
            return '0;
        if (wr_en && wr_idx == idx)
            return wr_data;                     // same-cycle write shows through
        return regs[idx];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++)
                regs[i] <= '0;
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rs1_idx = if_id.instr.rs1;
    assign rs2_idx = if_id.instr.rs2;
    assign imm_ext = {{16{if_id.instr.imm[15]}}, if_id.instr.imm};

    always_comb begin
        rs1_val = read_reg(rs1_idx);
        rs2_val = read_reg(rs2_idx);
    end

    always_comb begin
        id_payload = '0;                        // controls stay clear for bubbles
        id_no_op   = !if_id.valid;
        src_used   = 2'b00;
        use_imm    = 1'b0;
        if (if_id.valid) begin
            case (if_id.instr.opcode)
                isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND,
                isa_pkg::OP_OR, isa_pkg::OP_XOR: begin
                    id_payload.alu_op    = isa_pkg::alu_op_e'(if_id.instr.opcode[2:0]);
                    id_payload.reg_write = 1'b1;
                    src_used             = 2'b11;
                end
                isa_pkg::OP_ADDI: begin
                    id_payload.alu_op    = isa_pkg::ALU_ADD;
                    id_payload.reg_write = 1'b1;
                    src_used             = 2'b01;
                    use_imm              = 1'b1;
                end
                isa_pkg::OP_LW: begin
                    id_payload.alu_op    = isa_pkg::ALU_ADD;   // address = rs1 + imm
                    id_payload.reg_write = 1'b1;
                    id_payload.mem_read  = 1'b1;
                    src_used             = 2'b01;
                    use_imm              = 1'b1;
                end
                isa_pkg::OP_SW: begin
                    id_payload.alu_op    = isa_pkg::ALU_ADD;
                    id_payload.mem_write = 1'b1;
                    src_used             = 2'b11;              // rs2 is the store data
                    use_imm              = 1'b1;
                end
                default: id_no_op = 1'b1;       // NOP, HALT, unused codes
            endcase
        end
        id_payload.operand_1    = rs1_val;
        id_payload.operand_2    = use_imm ? imm_ext : rs2_val;
        id_payload.store_data   = rs2_val;
        id_payload.reg_1_idx    = rs1_idx;
        id_payload.reg_2_idx    = rs2_idx;
        id_payload.reg_dest_idx = if_id.instr.rd;
    end

endmodule

/* rtl/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage #(
    parameter isa_pkg::word_t RESET_PC = '0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              fetch_hold,       // decode may not hand its instruction on
    input  pipe_pkg::wb_rsp_t bus_rsp,
    output pipe_pkg::wb_req_t bus_req,          // instruction read master
    output pipe_pkg::if_id_t  if_id,
    output logic              halted
);

    pipe_pkg::bus_state_e state;
    isa_pkg::word_t       pc;
    logic                 is_halt;              // HALT waiting in decode
    logic                 start;

    assign is_halt = if_id.valid && (if_id.instr.opcode == isa_pkg::OP_HALT);
    // only fetch when the slot is empty or drains this cycle
    assign start   = !halted && !is_halt && (!if_id.valid || !fetch_hold);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= pipe_pkg::IDLE;
            bus_req <= '0;
            pc      <= RESET_PC;
            if_id   <= '0;
            halted  <= 1'b0;
        end else begin
            if (!fetch_hold) begin
                if_id.valid <= 1'b0;            // consumed by id_ex_reg
                if (is_halt)
                    halted <= 1'b1;             // sticky until reset
            end
            case (state)
                pipe_pkg::IDLE: begin
                    if (start) begin
                        bus_req.cyc <= 1'b1;
                        bus_req.stb <= 1'b1;
                        bus_req.we  <= 1'b0;    // fetch only reads
                        bus_req.adr <= pc;
                        bus_req.sel <= 4'hf;
                        state       <= pipe_pkg::WAIT_ACK;
                    end
                end
                pipe_pkg::WAIT_ACK: begin
                    if (bus_rsp.ack) begin
                        bus_req.cyc <= 1'b0;
                        bus_req.stb <= 1'b0;
                        if_id.instr <= isa_pkg::instr_t'(bus_rsp.dat_r);
                        if_id.valid <= 1'b1;    // start only fires with the slot free
                        pc          <= pc + 32'd4;
                        state       <= pipe_pkg::WAIT_ACK == state ? pipe_pkg::IDLE : state;
                    end
                end
                default: state <= pipe_pkg::IDLE;
            endcase
        end
    end

    // an ack only reaches fetch inside its own open read
    ack_in_own_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        bus_rsp.ack |-> state == pipe_pkg::WAIT_ACK);

endmodule

/* rtl/pipe_pkg.sv */
package pipe_pkg;

    typedef struct packed {
        logic hold;                             // keep execute payload, drop decode result
        logic no_op;                            // push a bubble into execute
    } hazard_ctrl_t;

    localparam hazard_ctrl_t HAZD_RESUME = '0;  // normal flow

    typedef struct packed {
        isa_pkg::instr_t instr;
        logic            valid;                 // slot holds an unconsumed instruction
    } if_id_t;

    typedef struct packed {
        logic              reg_write;
        logic              mem_write;
        logic              mem_read;
        isa_pkg::alu_op_e  alu_op;
        isa_pkg::word_t    operand_1;
        isa_pkg::word_t    operand_2;           // rs2 or immediate
        isa_pkg::word_t    store_data;          // rs2 value for SW
        isa_pkg::reg_idx_t reg_1_idx;
        isa_pkg::reg_idx_t reg_2_idx;
        isa_pkg::reg_idx_t reg_dest_idx;
    } id_ex_t;

    typedef struct packed {
        logic              reg_write;
        logic              mem_write;
        logic              mem_read;
        isa_pkg::word_t    result;              // ALU value or access address
        isa_pkg::word_t    store_data;
        isa_pkg::reg_idx_t reg_dest_idx;
        logic              valid;
    } ex_mem_t;

    typedef struct packed {
        logic           cyc;
        logic           stb;
        logic           we;
        isa_pkg::word_t adr;
        isa_pkg::word_t dat_w;
        logic [3:0]     sel;
    } wb_req_t;

    typedef struct packed {
        logic           ack;
        isa_pkg::word_t dat_r;
    } wb_rsp_t;

    typedef enum logic {
        IDLE,
        WAIT_ACK
    } bus_state_e;

endpackage

/* rtl/isa_pkg.sv */
package isa_pkg;

    typedef logic [31:0] word_t;                // data and byte address
    typedef logic [3:0]  reg_idx_t;             // r0..r15, r0 reads zero

    // register ops use codes 1..5, the same as their alu_op_e codes
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,                         // rd = rs1 + rs2
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_OR   = 4'h4,
        OP_XOR  = 4'h5,
        OP_ADDI = 4'h6,                         // rd = rs1 + imm
        OP_LW   = 4'h7,                         // rd = mem[rs1 + imm]
        OP_SW   = 4'h8,                         // mem[rs1 + imm] = rs2
        OP_HALT = 4'h9
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_PASS = 3'd0,                        // operand 2 straight through
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_AND  = 3'd3,
        ALU_OR   = 3'd4,
        ALU_XOR  = 3'd5
    } alu_op_e;

    typedef struct packed {
        opcode_e     opcode;                    // [31:28]
        reg_idx_t    rd;                        // [27:24]
        reg_idx_t    rs1;                       // [23:20]
        reg_idx_t    rs2;                       // [19:16]
        logic [15:0] imm;                       // sign extended in decode
    } instr_t;

endpackage
